// ==== files.f ====
+incdir+verification
source/rom_pkg.sv
source/dwnld_pkg.sv
source/rom_slot.sv
source/rom_arbiter.sv
source/prog_download.sv
source/game_rom_top.sv
verification/tb_game_rom.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f files.f --top-module tb_game_rom
out=$(./obj_dir/Vtb_game_rom)
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS"

// ==== verification/tb_game_rom_tests.svh ====
// Directed tests for the ROM access top, covering download, reads and caching
int passed, failed;

task automatic report(string name, int errs_before);
    if (errors == errs_before) passed++;
    else failed++;
    $display("%s %s", name, (errors == errs_before) ? "passed" : "failed");
endtask

task automatic set_downloading(logic on);
    @(posedge clk);
    downloading <= on;
endtask

// One loader byte, checked against the write it must produce
task automatic download_byte(logic [24:0] a, logic [7:0] d);
    dwnld_pkg::prog_wr_t exp;
    logic [15:0]         w;
    @(posedge clk);
    ioctl <= '{wr: 1'b1, addr: a, dout: d};
    @(posedge clk);
    ioctl.wr <= 1'b0;
    @(posedge clk);
    if (a >= PROM_START) begin
        exp = '{addr: 22'(a - PROM_START), data: d, mask: 2'b11};
        if (!prom_we || prog_we) begin
            $display("PROM write did not give prom_we alone");
            errors++;
        end
        check_prog(exp, prog);
        @(posedge clk);
        if (prom_we) begin
            $display("prom_we stayed high longer than one cycle");
            errors++;
        end
    end else begin
        exp = '{addr: a[22:1], data: d, mask: a[0] ? 2'b01 : 2'b10};
        if (!prog_we) begin
            $display("prog_we did not rise after a program write");
            errors++;
        end
        check_prog(exp, prog);
        w = image_word(a[22:1]);
        if (a[0]) w[15:8] = d;
        else w[7:0] = d;
        image_mem[a[22:1]] = w;
        while (prog_we) @(posedge clk);
    end
endtask

task automatic download_block(logic [24:0] base, int n);
    for (int i = 0; i < n; i++) download_byte(base + 25'(i), 8'($urandom));
endtask

task automatic test_variant();
    int e = errors;
    set_downloading(1'b1);
    download_byte(25'h0, 8'h7E);   // Alternate set marker
    download_block(25'h1, 47);
    download_block(25'h2_8000, 48);   // Sub region
    download_block(25'h3_0000, 48);   // Sound region
    download_block(25'h4_0000, 48);   // Graphics region
    set_downloading(1'b0);
    check_variant(dwnld_pkg::VARIANT_ALT, variant);
    set_downloading(1'b1);
    download_byte(25'h0, 8'h3C);
    download_block(25'h1, 15);
    set_downloading(1'b0);
    check_variant(dwnld_pkg::VARIANT_BASE, variant);
    report("variant detection", e);
endtask

task automatic test_prog_writes();
    int e = errors;
    foreach (image_mem[k]) begin
        check_word("sdram_mem", 32'(image_mem[k]), 32'(model_word(22'(k))));
    end
    report("sdram program writes", e);
endtask

task automatic test_prom();
    int e = errors;
    set_downloading(1'b1);
    download_byte(PROM_START + 25'd5, 8'hA5);
    set_downloading(1'b0);
    report("prom writes", e);
endtask

function automatic rom_pkg::sdram_addr_t slot_offset(int slot);
    case (slot)
        1: return 22'h1_4000;
        2: return 22'h1_8000;
        3: return 22'h2_0000;
        default: return 22'h0;
    endcase
endfunction

function automatic logic [7:0] expect_byte(int slot, logic [17:0] a);
    logic [15:0] w;
    w = image_word(slot_offset(slot) + 22'(a >> 1));
    return a[0] ? w[15:8] : w[7:0];
endfunction

function automatic rom_pkg::sdram_data_t expect_beat(logic [17:0] a);
    rom_pkg::sdram_addr_t w;
    w = slot_offset(3) + 22'({a, 1'b0});
    return {image_word(w + 22'd1), image_word(w)};
endfunction

function automatic logic ok_of(int slot);
    return (slot == 0) ? main_ok : (slot == 1) ? sub_ok : (slot == 2) ? snd_ok : gfx_ok;
endfunction

task automatic check_slot(int slot, logic [17:0] a);
    case (slot)
        0: check_byte("main_dout", expect_byte(0, a), main_dout);
        1: check_byte("sub_dout", expect_byte(1, a), sub_dout);
        2: check_byte("snd_dout", expect_byte(2, a), snd_dout);
        default: check_word("gfx_dout", expect_beat(a), gfx_dout);
    endcase
endtask

task automatic drive_slot(int slot, logic cs, logic [17:0] a);
    case (slot)
        0: begin
            main_cs   <= cs;
            main_addr <= a;
        end
        1: begin
            sub_cs   <= cs;
            sub_addr <= 15'(a);
        end
        2: begin
            snd_cs   <= cs;
            snd_addr <= 15'(a);
        end
        default: begin
            gfx_cs   <= cs;
            gfx_addr <= a;
        end
    endcase
endtask

task automatic read_slot(int slot, logic [17:0] a);
    @(posedge clk);
    drive_slot(slot, 1'b1, a);
    do @(posedge clk); while (!ok_of(slot));
    check_slot(slot, a);
    drive_slot(slot, 1'b0, a);
endtask

task automatic test_single_reads();
    int e = errors;
    read_slot(0, 18'd5);
    read_slot(1, 18'd20);
    read_slot(2, 18'd33);
    read_slot(3, 18'd7);
    report("single reads", e);
endtask

task automatic test_concurrent();
    logic [17:0] a [4] = '{18'd17, 18'd41, 18'd8, 18'd3};
    logic [3:0]  seen = '0;
    int e = errors;
    @(posedge clk);
    for (int s = 0; s < 4; s++) drive_slot(s, 1'b1, a[s]);
    while (seen != 4'hF) begin
        @(posedge clk);
        for (int s = 0; s < 4; s++) begin
            if (!seen[s] && ok_of(s)) begin
                check_slot(s, a[s]);
                seen[s] = 1'b1;
            end
        end
    end
    for (int s = 0; s < 4; s++) drive_slot(s, 1'b0, a[s]);
    report("concurrent requests", e);
endtask

task automatic test_cache();
    int e = errors;
    int n;
    @(posedge clk);
    drive_slot(0, 1'b1, 18'd40);
    do @(posedge clk); while (!main_ok);
    check_slot(0, 18'd40);
    n = reads;
    main_addr <= 18'd41;   // Other byte of the cached word
    repeat (2) @(posedge clk);
    if (!main_ok) begin
        $display("main_ok did not rise one cycle after a cache hit");
        errors++;
    end
    check_slot(0, 18'd41);
    // A miss would reach the SDRAM model within a few cycles
    repeat (4) @(posedge clk);
    if (reads != n) begin
        $display("cache hit still sent a read to SDRAM");
        errors++;
    end
    drive_slot(0, 1'b0, 18'd41);
    set_downloading(1'b1);
    download_byte(25'h100, 8'($urandom));
    set_downloading(1'b0);
    n = reads;
    read_slot(0, 18'd40);
    if (reads == n) begin
        $display("read after a new download did not reach SDRAM");
        errors++;
    end
    report("cache hits", e);
endtask

// ==== verification/tb_game_rom.sv ====
// Testbench for the ROM access top with an SDRAM model and directed tests
`timescale 1ns/1ns

module tb_game_rom;
    localparam logic [24:0] PROM_START = 25'hC_0000;
    localparam int          MAX_CYCLES = 4000;

    logic clk, reset, downloading, prog_we, prom_we, sdram_ack, data_rdy;
    logic main_cs, sub_cs, snd_cs, gfx_cs, main_ok, sub_ok, snd_ok, gfx_ok;
    logic [17:0] main_addr, gfx_addr;
    logic [14:0] sub_addr, snd_addr;
    logic [7:0]  main_dout, sub_dout, snd_dout;
    logic [31:0] gfx_dout;
    dwnld_pkg::ioctl_t        ioctl;
    dwnld_pkg::prog_wr_t      prog;
    dwnld_pkg::game_variant_e variant;
    rom_pkg::sdram_rd_t       sdram;
    rom_pkg::sdram_data_t     data_read;
    logic [15:0] sdram_mem [int];   // SDRAM model contents
    logic [15:0] image_mem [int];   // Image as downloaded
    int errors, reads, cycles;
    logic outstanding;

    game_rom_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Unwritten words read back a pattern of their address
    function automatic logic [15:0] fill_word(rom_pkg::sdram_addr_t a);
        return a[15:0] ^ {10'h0, a[21:16]};
    endfunction

    function automatic logic [15:0] model_word(rom_pkg::sdram_addr_t a);
        return sdram_mem.exists(a) ? sdram_mem[a] : fill_word(a);
    endfunction

    function automatic logic [15:0] image_word(rom_pkg::sdram_addr_t a);
        return image_mem.exists(a) ? image_mem[a] : fill_word(a);
    endfunction

    task automatic check_byte(string name, logic [7:0] exp, logic [7:0] act);
        if (exp !== act) begin
            $display("Error: %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(string name, rom_pkg::sdram_data_t exp, rom_pkg::sdram_data_t act);
        if (exp !== act) begin
            $display("Error: %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_variant(dwnld_pkg::game_variant_e exp, dwnld_pkg::game_variant_e act);
        if (exp !== act) begin
            $display("Error: variant expected %h got %h", exp, act);
            errors++;
        end
    endtask

    task automatic check_prog(dwnld_pkg::prog_wr_t exp, dwnld_pkg::prog_wr_t act);
        if (exp !== act) begin
            $display("Error: prog expected %h got %h", exp, act);
            errors++;
        end
    endtask

    // SDRAM model, acks writes while downloading and reads otherwise
    initial begin : sdram_model
        dwnld_pkg::prog_wr_t  wr;
        rom_pkg::sdram_addr_t ra;
        logic [15:0]          w;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            if (downloading && prog_we) begin
                wr = prog;
                repeat ($urandom_range(4, 1) - 1) @(posedge clk);
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
                w = model_word(wr.addr);
                if (!wr.mask[0]) w[7:0] = wr.data;
                if (!wr.mask[1]) w[15:8] = wr.data;
                sdram_mem[wr.addr] = w;
            end else if (!downloading && sdram.req) begin
                ra = sdram.addr;
                reads++;
                repeat ($urandom_range(4, 1) - 1) @(posedge clk);
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
                repeat ($urandom_range(4, 1) - 1) @(posedge clk);
                data_rdy  <= 1'b1;
                data_read <= {model_word(ra + 22'd1), model_word(ra)};
                @(posedge clk);
                data_rdy  <= 1'b0;
            end
        end
    end

    // One read in flight at a time, and the run limit
    always @(posedge clk) begin
        cycles++;
        if (reset) begin
            outstanding <= 1'b0;
        end else begin
            if (sdram.req && outstanding) begin
                $display("SDRAM read issued before the previous data_rdy");
                errors++;
            end
            if (sdram.req && sdram_ack) outstanding <= 1'b1;
            else if (data_rdy) outstanding <= 1'b0;
        end
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    `include "tb_game_rom_tests.svh"

    initial begin
        void'($urandom(62556));
        reset = 1'b1;
        downloading = 1'b0;
        ioctl = '0;
        {main_cs, sub_cs, snd_cs, gfx_cs} = '0;
        {main_addr, sub_addr, snd_addr, gfx_addr} = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        test_variant();
        test_prog_writes();
        test_prom();
        test_single_reads();
        test_concurrent();
        test_cache();
        $display("Tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== source/game_rom_top.sv ====
// ROM access top joining the download unit, four client slots and the SDRAM read arbiter
`timescale 1ns/1ns

module game_rom_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     downloading,
    input  dwnld_pkg::ioctl_t        ioctl,
    output dwnld_pkg::prog_wr_t      prog,
    output logic                     prog_we,
    output logic                     prom_we,
    output dwnld_pkg::game_variant_e variant,
    input  logic                     main_cs,
    input  logic [17:0]              main_addr,
    output logic                     main_ok,
    output logic [7:0]               main_dout,
    input  logic                     sub_cs,
    input  logic [14:0]              sub_addr,
    output logic                     sub_ok,
    output logic [7:0]               sub_dout,
    input  logic                     snd_cs,
    input  logic [14:0]              snd_addr,
    output logic                     snd_ok,
    output logic [7:0]               snd_dout,
    input  logic                     gfx_cs,
    input  logic [17:0]              gfx_addr,
    output logic                     gfx_ok,
    output logic [31:0]              gfx_dout,
    output rom_pkg::sdram_rd_t       sdram,
    input  logic                     sdram_ack,
    input  logic                     data_rdy,
    input  rom_pkg::sdram_data_t     data_read
);
    localparam rom_pkg::sdram_addr_t SUB_OFFSET = 22'h1_4000;
    localparam rom_pkg::sdram_addr_t SND_OFFSET = 22'h1_8000;
    localparam rom_pkg::sdram_addr_t GFX_OFFSET = 22'h2_0000;
    localparam logic [24:0]          PROM_START = 25'hC_0000;   // Colour PROMs

    logic [rom_pkg::NUM_SLOTS-1:0]                 slot_req, slot_grant, slot_valid;
    rom_pkg::sdram_addr_t [rom_pkg::NUM_SLOTS-1:0] slot_addr;
    rom_pkg::sdram_data_t                          rd_data;

    prog_download #(.PROM_START(PROM_START)) u_dwnld (
        .clk(clk), .reset(reset), .downloading(downloading), .ioctl(ioctl),
        .sdram_ack(sdram_ack), .prog(prog), .prog_we(prog_we), .prom_we(prom_we),
        .variant(variant)
    );

    rom_slot #(.AW(18), .DW(8), .OFFSET(22'h0)) u_main (   // Main CPU
        .clk(clk), .reset(reset), .downloading(downloading), .cs(main_cs),
        .addr(main_addr), .grant(slot_grant[0]), .data_valid(slot_valid[0]),
        .data_in(rd_data), .ok(main_ok), .dout(main_dout),
        .req(slot_req[0]), .req_addr(slot_addr[0])
    );

    rom_slot #(.AW(15), .DW(8), .OFFSET(SUB_OFFSET)) u_sub (
        .clk(clk), .reset(reset), .downloading(downloading), .cs(sub_cs),
        .addr(sub_addr), .grant(slot_grant[1]), .data_valid(slot_valid[1]),
        .data_in(rd_data), .ok(sub_ok), .dout(sub_dout),
        .req(slot_req[1]), .req_addr(slot_addr[1])
    );

    rom_slot #(.AW(15), .DW(8), .OFFSET(SND_OFFSET)) u_snd (
        .clk(clk), .reset(reset), .downloading(downloading), .cs(snd_cs),
        .addr(snd_addr), .grant(slot_grant[2]), .data_valid(slot_valid[2]),
        .data_in(rd_data), .ok(snd_ok), .dout(snd_dout),
        .req(slot_req[2]), .req_addr(slot_addr[2])
    );

    rom_slot #(.AW(18), .DW(32), .OFFSET(GFX_OFFSET)) u_gfx (   // Full beats
        .clk(clk), .reset(reset), .downloading(downloading), .cs(gfx_cs),
        .addr(gfx_addr), .grant(slot_grant[3]), .data_valid(slot_valid[3]),
        .data_in(rd_data), .ok(gfx_ok), .dout(gfx_dout),
        .req(slot_req[3]), .req_addr(slot_addr[3])
    );

    rom_arbiter u_arb (
        .clk(clk), .reset(reset), .downloading(downloading),
        .req(slot_req), .req_addr(slot_addr),
        .sdram_ack(sdram_ack), .data_rdy(data_rdy), .data_read(data_read),
        .sdram(sdram), .grant(slot_grant), .data_valid(slot_valid), .data_out(rd_data)
    );

endmodule

// ==== source/prog_download.sv ====
// Download unit turning loader bytes into SDRAM or PROM writes and detecting the game set
`timescale 1ns/1ns

module prog_download #(
    parameter logic [24:0] PROM_START = 25'hC_0000
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      downloading,
    input  dwnld_pkg::ioctl_t         ioctl,
    input  logic                      sdram_ack,
    output dwnld_pkg::prog_wr_t       prog,
    output logic                      prog_we,
    output logic                      prom_we,
    output dwnld_pkg::game_variant_e  variant
);
    logic        accept;
    logic        is_prom;
    logic [24:0] prom_off;

    assign accept   = downloading && ioctl.wr;
    assign is_prom  = ioctl.addr >= PROM_START;
    assign prom_off = ioctl.addr - PROM_START;

    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
            variant <= dwnld_pkg::VARIANT_BASE;
        end else begin
            prom_we <= 1'b0;   // Single cycle strobe
            if (accept) begin
                prog.data <= ioctl.dout;
                if (is_prom) begin
                    prom_we   <= 1'b1;
                    prog.addr <= prom_off[21:0];
                    prog.mask <= 2'b11;      // No SDRAM byte lane
                end else begin
                    prog_we   <= 1'b1;
                    prog.addr <= ioctl.addr[22:1];
                    prog.mask <= ioctl.addr[0] ? 2'b01 : 2'b10;
                end
                // First byte tells the game sets apart
                if (ioctl.addr == '0) begin
                    variant <= (ioctl.dout == dwnld_pkg::VARIANT_MARK) ?
                               dwnld_pkg::VARIANT_ALT : dwnld_pkg::VARIANT_BASE;
                end
            end else if (prog_we && sdram_ack) begin
                prog_we <= 1'b0;
            end
        end
    end

endmodule

// ==== source/rom_arbiter.sv ====
// Round-robin arbiter sharing the single SDRAM read port between the ROM slots
`timescale 1ns/1ns

module rom_arbiter (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          downloading,
    input  logic [rom_pkg::NUM_SLOTS-1:0]                 req,
    input  rom_pkg::sdram_addr_t [rom_pkg::NUM_SLOTS-1:0] req_addr,
    input  logic                                          sdram_ack,
    input  logic                                          data_rdy,
    input  rom_pkg::sdram_data_t                          data_read,
    output rom_pkg::sdram_rd_t                            sdram,
    output logic [rom_pkg::NUM_SLOTS-1:0]                 grant,
    output logic [rom_pkg::NUM_SLOTS-1:0]                 data_valid,
    output rom_pkg::sdram_data_t                          data_out
);
    localparam int SW = $clog2(rom_pkg::NUM_SLOTS);

    rom_pkg::arb_state_e           state;
    logic [SW-1:0]                 last;    // Slot served most recently
    logic [SW-1:0]                 sel;     // Slot being served
    logic [SW-1:0]                 next;
    logic [SW-1:0]                 idx;
    logic                          found;
    logic [rom_pkg::NUM_SLOTS-1:0] sel_onehot;

    // First requester after the last one served
    always_comb begin
        next  = last;
        found = 1'b0;
        idx   = last;
        for (int i = 1; i <= rom_pkg::NUM_SLOTS; i++) begin
            idx = SW'((int'(last) + i) % rom_pkg::NUM_SLOTS);
            if (!found && req[idx]) begin
                next  = idx;
                found = 1'b1;
            end
        end
    end

    assign sel_onehot = {{(rom_pkg::NUM_SLOTS-1){1'b0}}, 1'b1} << sel;
    assign grant      = (state == rom_pkg::ARB_IDLE) ? '0 : sel_onehot;
    assign data_valid = (state == rom_pkg::ARB_DATA && data_rdy) ? sel_onehot : '0;
    assign data_out   = data_read;   // Only the strobed slot takes it

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= rom_pkg::ARB_IDLE;
            sdram.req <= 1'b0;
            last      <= SW'(rom_pkg::NUM_SLOTS - 1);   // Slot 0 goes first
            sel       <= '0;
        end else begin
            case (state)
                rom_pkg::ARB_IDLE: begin
                    // SDRAM belongs to the loader while downloading
                    if (found && !downloading) begin
                        sel        <= next;
                        sdram.req  <= 1'b1;
                        sdram.addr <= req_addr[next];
                        state      <= rom_pkg::ARB_ACK;
                    end
                end
                rom_pkg::ARB_ACK: begin
                    if (sdram_ack) begin
                        sdram.req <= 1'b0;
                        state     <= rom_pkg::ARB_DATA;
                    end
                end
                rom_pkg::ARB_DATA: begin
                    if (data_rdy) begin
                        last  <= sel;
                        state <= rom_pkg::ARB_IDLE;
                    end
                end
                default: state <= rom_pkg::ARB_IDLE;
            endcase
        end
    end

endmodule

// ==== source/rom_slot.sv ====
// ROM client slot that maps a client address onto SDRAM and keeps one cached word
`timescale 1ns/1ns

module rom_slot #(
    parameter int                   AW     = 18,
    parameter int                   DW     = 8,
    parameter rom_pkg::sdram_addr_t OFFSET = '0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 downloading,
    input  logic                 cs,
    input  logic [AW-1:0]        addr,
    input  logic                 grant,
    input  logic                 data_valid,
    input  rom_pkg::sdram_data_t data_in,
    output logic                 ok,
    output logic [DW-1:0]        dout,
    output logic                 req,
    output rom_pkg::sdram_addr_t req_addr
);
    rom_pkg::slot_state_e state;
    rom_pkg::sdram_addr_t word_addr;
    rom_pkg::sdram_addr_t cache_addr;
    rom_pkg::sdram_data_t cache_data;
    logic [AW-1:0]        ok_addr;   // Client address that dout belongs to
    logic                 ok_q;
    logic                 hit;

    // Byte lane for 8-bit clients, whole beat otherwise
    function automatic logic [DW-1:0] pick(rom_pkg::sdram_data_t beat, logic odd);
        if (DW == 32) begin
            return DW'(beat);
        end
        return DW'(odd ? beat[15:8] : beat[7:0]);
    endfunction

    // 8-bit clients address bytes, 32-bit clients address two-word beats
    assign word_addr = (DW == 32) ? OFFSET + rom_pkg::sdram_addr_t'({addr, 1'b0})
                                  : OFFSET + rom_pkg::sdram_addr_t'(addr >> 1);

    assign hit = (state == rom_pkg::SLOT_VALID) && (word_addr == cache_addr);
    assign ok  = ok_q && cs && (addr == ok_addr);   // Drops at once on a new address

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rom_pkg::SLOT_IDLE;
            ok_q  <= 1'b0;
            req   <= 1'b0;
        end else if (downloading) begin
            state <= rom_pkg::SLOT_IDLE;   // ROM contents are changing
            ok_q  <= 1'b0;
            req   <= 1'b0;
        end else begin
            case (state)
                rom_pkg::SLOT_WAIT: begin
                    if (grant) begin
                        req <= 1'b0;   // Arbiter holds the address now
                    end
                    if (data_valid) begin
                        state      <= rom_pkg::SLOT_VALID;
                        cache_addr <= req_addr;
                        cache_data <= data_in;
                        ok_q       <= cs && (word_addr == req_addr);
                        ok_addr    <= addr;
                        dout       <= pick(data_in, addr[0]);
                    end
                end
                default: begin
                    ok_q    <= cs && hit;
                    ok_addr <= addr;
                    dout    <= pick(cache_data, addr[0]);
                    if (cs && !hit) begin
                        state    <= rom_pkg::SLOT_WAIT;
                        req      <= 1'b1;
                        req_addr <= word_addr;
                    end
                end
            endcase
        end
    end

endmodule

// ==== source/dwnld_pkg.sv ====
// Loader stream, program write and game variant types for the ROM download
package dwnld_pkg;

    // First byte of the alternate game set
    localparam logic [7:0] VARIANT_MARK = 8'h7E;

    typedef struct packed {
        logic        wr;
        logic [24:0] addr;   // Byte address
        logic [7:0]  dout;
    } ioctl_t;

    typedef struct packed {
        logic [21:0] addr;   // Word address, or PROM offset
        logic [7:0]  data;
        logic [1:0]  mask;   // Active low byte enables
    } prog_wr_t;

    typedef enum logic {
        VARIANT_BASE,
        VARIANT_ALT
    } game_variant_e;

endpackage

// ==== source/rom_pkg.sv ====
// ROM read side types shared by the client slots and the SDRAM read arbiter
package rom_pkg;

    // Slot request lines into the arbiter
    localparam int NUM_SLOTS = 4;

    // SDRAM address of one 16-bit word
    typedef logic [21:0] sdram_addr_t;

    // One read beat, two consecutive words, lower address in the low half
    typedef logic [31:0] sdram_data_t;

    typedef struct packed {
        logic        req;
        sdram_addr_t addr;
    } sdram_rd_t;

    typedef enum logic [1:0] {
        SLOT_IDLE,
        SLOT_WAIT,   // Miss sent to the arbiter
        SLOT_VALID   // Cached word usable
    } slot_state_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ACK,     // Request out, waiting for sdram_ack
        ARB_DATA     // Waiting for data_rdy
    } arb_state_e;

endpackage
